// ==== src/stack_cpu_pkg.sv ====
package stack_cpu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operation and address control codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,
        OP_SUB   = 4'd2,
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_ADDI  = 4'd5,
        OP_PUSH  = 4'd6,
        OP_POP   = 4'd7,
        OP_SETSP = 4'd8,
        OP_BL    = 4'd9,
        OP_BEQ   = 4'd10
    } opcode_e;

    typedef enum logic [2:0] {
        ADDR_NONE  = 3'd0,
        ADDR_PUSH  = 3'd1,
        ADDR_POP   = 3'd2,
        ADDR_SETSP = 3'd3,
        ADDR_BL    = 3'd4
    } addr_ctrl_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction word, decoded as ALU form or stack form
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        opcode_e     opcode;   // Bits 31:28
        logic [1:0]  rd;
        logic [1:0]  ra;
        logic [1:0]  rb;
        logic [3:0]  rsvd;     // Bits 21:18, ignored
        logic [17:0] imm;      // Signed immediate
    } alu_form_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [1:0]  rd;
        logic [1:0]  rs;
        logic [1:0]  rsvd;     // Bits 23:22, ignored
        logic [21:0] target;   // Absolute word address
    } stack_form_t;

    typedef union packed {
        alu_form_t   alu_form;
        stack_form_t stack_form;
    } instr_word_u;

    // APB register map
    localparam logic [7:0] REG_EXEC = 8'h00;
    localparam logic [7:0] REG_PC   = 8'h04;
    localparam logic [7:0] REG_SP   = 8'h08;
    localparam logic [7:0] REG_MODE = 8'h0C;
    localparam logic [7:0] REG_GPR0 = 8'h10;
    localparam logic [7:0] REG_GPR1 = 8'h14;
    localparam logic [7:0] REG_GPR2 = 8'h18;
    localparam logic [7:0] REG_GPR3 = 8'h1C;

endpackage

// ==== src/exec_alu.sv ====
`timescale 1ns/100ps

module exec_alu import stack_cpu_pkg::*; #(
    parameter int WORD_SIZE = 32
) (
    input  instr_word_u            instr,
    input  logic [WORD_SIZE-1:0]   a_val,
    input  logic [WORD_SIZE-1:0]   b_val,
    output logic [WORD_SIZE-1:0]   alu_result,
    output logic                   take_branch
);

    logic [WORD_SIZE-1:0] imm_ext;
    opcode_e              op;

    assign op = instr.alu_form.opcode;

    // Sign extend the 18 bit immediate
    assign imm_ext = {{(WORD_SIZE - 18){instr.alu_form.imm[17]}}, instr.alu_form.imm};

    always_comb begin
        case (op)
            OP_ADD: begin
                alu_result = a_val + b_val;
            end
            OP_SUB: begin
                alu_result = a_val - b_val;
            end
            OP_AND: begin
                alu_result = a_val & b_val;
            end
            OP_OR: begin
                alu_result = a_val | b_val;
            end
            OP_ADDI: begin
                alu_result = a_val + imm_ext;
            end
            default: begin
                alu_result = '0;    // Stack ops and NOP
            end
        endcase
    end

    // BEQ compares rd against rs, as selected by the controller
    always_comb begin
        take_branch = 1'b0;
        if (op == OP_BEQ) begin
            take_branch = (a_val == b_val);
        end
    end

endmodule

// ==== src/mem_address_handler.sv ====
`timescale 1ns/100ps

module mem_address_handler import stack_cpu_pkg::*; #(
    parameter int WORD_SIZE           = 32,
    parameter int KERNEL_STACK_TOP    = 4096,
    parameter int KERNEL_STACK_BOTTOM = 6143,
    parameter int USER_STACK_TOP      = 6144,
    parameter int USER_STACK_BOTTOM   = 8191
) (
    input  instr_word_u            instr,
    input  logic                   is_kernel,
    input  logic [WORD_SIZE-1:0]   current_pc,
    input  logic [WORD_SIZE-1:0]   current_sp,
    input  logic [WORD_SIZE-1:0]   src_val,
    output logic [WORD_SIZE-1:0]   next_sp,
    output logic [WORD_SIZE-1:0]   mem_addr,
    output logic [WORD_SIZE-1:0]   link_value,
    output logic [WORD_SIZE-1:0]   branch_target
);

    addr_ctrl_e           control;
    logic [WORD_SIZE-1:0] top_stack;
    logic [WORD_SIZE-1:0] bottom_stack;

    // Opcode to address control code
    always_comb begin
        case (instr.stack_form.opcode)
            OP_PUSH:  control = ADDR_PUSH;
            OP_POP:   control = ADDR_POP;
            OP_SETSP: control = ADDR_SETSP;
            OP_BL:    control = ADDR_BL;
            default:  control = ADDR_NONE;
        endcase
    end

    // Bounds of the active stack
    assign top_stack    = is_kernel ? WORD_SIZE'(KERNEL_STACK_TOP)
                                    : WORD_SIZE'(USER_STACK_TOP);
    assign bottom_stack = is_kernel ? WORD_SIZE'(KERNEL_STACK_BOTTOM)
                                    : WORD_SIZE'(USER_STACK_BOTTOM);

    assign link_value    = current_pc + 1'b1;
    assign branch_target = WORD_SIZE'(instr.stack_form.target);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stack pointer arithmetic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (control)
            ADDR_PUSH: begin
                next_sp  = (current_sp > top_stack) ? current_sp - 1'b1 : top_stack;
                mem_addr = next_sp;                     // Store at new SP
            end
            ADDR_POP: begin
                next_sp  = (current_sp < bottom_stack) ? current_sp + 1'b1 : bottom_stack;
                mem_addr = current_sp;                  // Load from old SP
            end
            ADDR_SETSP: begin
                next_sp  = src_val;
                mem_addr = src_val;
            end
            ADDR_BL: begin
                next_sp  = current_sp;                  // No repair on branch
                mem_addr = branch_target;
            end
            default: begin
                // Zero SP means not yet set up, park it at the bottom
                next_sp  = (current_sp == '0) ? bottom_stack : current_sp;
                mem_addr = current_sp;
            end
        endcase
    end

endmodule

// ==== src/step_controller.sv ====
`timescale 1ns/100ps

module step_controller import stack_cpu_pkg::*; #(
    parameter int WORD_SIZE = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [WORD_SIZE-1:0]   pwdata,
    output logic [WORD_SIZE-1:0]   prdata,
    output logic                   pready,
    output logic                   pslverr,
    output instr_word_u            instr,
    output logic                   is_kernel,
    output logic [WORD_SIZE-1:0]   current_pc,
    output logic [WORD_SIZE-1:0]   current_sp,
    output logic [WORD_SIZE-1:0]   a_val,
    output logic [WORD_SIZE-1:0]   b_val,
    input  logic [WORD_SIZE-1:0]   alu_result,
    input  logic [WORD_SIZE-1:0]   next_sp,
    input  logic [WORD_SIZE-1:0]   mem_addr,
    input  logic [WORD_SIZE-1:0]   link_value,
    input  logic [WORD_SIZE-1:0]   branch_target,
    input  logic                   take_branch,
    output logic                   ram_we,
    output logic [WORD_SIZE-1:0]   ram_addr,
    output logic [WORD_SIZE-1:0]   ram_wdata,
    input  logic [WORD_SIZE-1:0]   ram_rdata
);

    logic [WORD_SIZE-1:0] gpr [4];
    logic                 access;
    logic                 exec_fire;
    logic                 mode_wr;
    logic                 read_ok;
    logic                 write_ok;
    logic [WORD_SIZE-1:0] rd_mux;
    logic [WORD_SIZE-1:0] pc_next;
    logic [WORD_SIZE-1:0] rd_data;
    logic                 rd_we;
    opcode_e              op;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB slave
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign access    = psel & penable;
    assign pready    = 1'b1;                               // Zero wait states
    assign exec_fire = access & pwrite & (paddr == REG_EXEC);
    assign mode_wr   = access & pwrite & (paddr == REG_MODE);

    always_comb begin
        read_ok  = 1'b0;
        write_ok = 1'b0;
        rd_mux   = '0;
        case (paddr)
            REG_EXEC: write_ok = 1'b1;                     // Write only
            REG_PC: begin
                read_ok = 1'b1;
                rd_mux  = current_pc;
            end
            REG_SP: begin
                read_ok = 1'b1;
                rd_mux  = current_sp;
            end
            REG_MODE: begin
                read_ok  = 1'b1;
                write_ok = 1'b1;
                rd_mux   = WORD_SIZE'(is_kernel);
            end
            REG_GPR0: begin
                read_ok = 1'b1;
                rd_mux  = gpr[0];
            end
            REG_GPR1: begin
                read_ok = 1'b1;
                rd_mux  = gpr[1];
            end
            REG_GPR2: begin
                read_ok = 1'b1;
                rd_mux  = gpr[2];
            end
            REG_GPR3: begin
                read_ok = 1'b1;
                rd_mux  = gpr[3];
            end
            default: ;                                      // Unknown offset
        endcase
    end

    assign prdata  = (access && !pwrite) ? rd_mux : '0;
    assign pslverr = access && (pwrite ? !write_ok : !read_ok);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode and operand select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign instr = pwdata;                                  // Decode bus
    assign op    = instr.alu_form.opcode;

    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI: begin
                a_val = gpr[instr.alu_form.ra];
                b_val = gpr[instr.alu_form.rb];
            end
            default: begin                                  // Stack form uses rd, rs
                a_val = gpr[instr.stack_form.rd];
                b_val = gpr[instr.stack_form.rs];
            end
        endcase
    end

    // Result selection per opcode
    always_comb begin
        pc_next = link_value;
        rd_data = alu_result;
        rd_we   = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI: rd_we = 1'b1;
            OP_POP: begin
                rd_data = ram_rdata;
                rd_we   = 1'b1;
            end
            OP_BL: begin
                rd_data = link_value;                       // Return address
                rd_we   = 1'b1;
                pc_next = branch_target;
            end
            OP_BEQ: pc_next = take_branch ? branch_target : link_value;
            default: ;
        endcase
    end

    assign ram_we    = exec_fire && (op == OP_PUSH);
    assign ram_addr  = mem_addr;
    assign ram_wdata = b_val;                               // Value of rs

    // Architectural state
    always_ff @(posedge clk) begin
        if (reset) begin
            current_pc <= '0;
            current_sp <= '0;
            is_kernel  <= 1'b1;                             // Boot in kernel mode
            for (int i = 0; i < 4; i++) begin
                gpr[i] <= '0;
            end
        end else begin
            if (exec_fire) begin
                current_pc <= pc_next;
                current_sp <= next_sp;
                if (rd_we) begin
                    gpr[instr.alu_form.rd] <= rd_data;
                end
            end
            if (mode_wr) begin
                is_kernel <= pwdata[0];
            end
        end
    end

endmodule

// ==== src/stack_ram.sv ====
`timescale 1ns/100ps

module stack_ram #(
    parameter int WORD_SIZE         = 32,
    parameter int KERNEL_STACK_TOP  = 4096,
    parameter int USER_STACK_BOTTOM = 8191
) (
    input  logic                   clk,
    input  logic                   we,
    input  logic [WORD_SIZE-1:0]   addr,
    input  logic [WORD_SIZE-1:0]   wdata,
    output logic [WORD_SIZE-1:0]   rdata
);

    localparam int DEPTH = USER_STACK_BOTTOM - KERNEL_STACK_TOP + 1;
    localparam int AW    = $clog2(DEPTH);

    logic [WORD_SIZE-1:0] mem [DEPTH];
    logic [WORD_SIZE-1:0] offset;
    logic                 in_range;

    assign offset   = addr - WORD_SIZE'(KERNEL_STACK_TOP);  // Rebase to stack region
    assign in_range = (addr >= WORD_SIZE'(KERNEL_STACK_TOP)) &&
                      (addr <= WORD_SIZE'(USER_STACK_BOTTOM));

    always_ff @(posedge clk) begin
        if (we && in_range) begin
            mem[offset[AW-1:0]] <= wdata;
        end
    end

    assign rdata = in_range ? mem[offset[AW-1:0]] : '0;

endmodule

// ==== src/stack_cpu_top.sv ====
`timescale 1ns/100ps

module stack_cpu_top import stack_cpu_pkg::*; #(
    parameter int WORD_SIZE           = 32,
    parameter int KERNEL_STACK_TOP    = 4096,
    parameter int KERNEL_STACK_BOTTOM = 6143,
    parameter int USER_STACK_TOP      = 6144,
    parameter int USER_STACK_BOTTOM   = 8191
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [WORD_SIZE-1:0]   pwdata,
    output logic [WORD_SIZE-1:0]   prdata,
    output logic                   pready,
    output logic                   pslverr
);

    instr_word_u          instr;
    logic                 is_kernel;
    logic                 take_branch;
    logic                 ram_we;
    logic [WORD_SIZE-1:0] current_pc;
    logic [WORD_SIZE-1:0] current_sp;
    logic [WORD_SIZE-1:0] a_val;
    logic [WORD_SIZE-1:0] b_val;
    logic [WORD_SIZE-1:0] alu_result;
    logic [WORD_SIZE-1:0] next_sp;
    logic [WORD_SIZE-1:0] mem_addr;
    logic [WORD_SIZE-1:0] link_value;
    logic [WORD_SIZE-1:0] branch_target;
    logic [WORD_SIZE-1:0] ram_addr;
    logic [WORD_SIZE-1:0] ram_wdata;
    logic [WORD_SIZE-1:0] ram_rdata;

    step_controller #(
        .WORD_SIZE (WORD_SIZE)
    ) u_step_controller (
        .clk           (clk),
        .reset         (reset),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .instr         (instr),
        .is_kernel     (is_kernel),
        .current_pc    (current_pc),
        .current_sp    (current_sp),
        .a_val         (a_val),
        .b_val         (b_val),
        .alu_result    (alu_result),
        .next_sp       (next_sp),
        .mem_addr      (mem_addr),
        .link_value    (link_value),
        .branch_target (branch_target),
        .take_branch   (take_branch),
        .ram_we        (ram_we),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata),
        .ram_rdata     (ram_rdata)
    );

    exec_alu #(
        .WORD_SIZE (WORD_SIZE)
    ) u_exec_alu (
        .instr       (instr),
        .a_val       (a_val),
        .b_val       (b_val),
        .alu_result  (alu_result),
        .take_branch (take_branch)
    );

    // Stack operand rs arrives on b_val
    mem_address_handler #(
        .WORD_SIZE           (WORD_SIZE),
        .KERNEL_STACK_TOP    (KERNEL_STACK_TOP),
        .KERNEL_STACK_BOTTOM (KERNEL_STACK_BOTTOM),
        .USER_STACK_TOP      (USER_STACK_TOP),
        .USER_STACK_BOTTOM   (USER_STACK_BOTTOM)
    ) u_mem_address_handler (
        .instr         (instr),
        .is_kernel     (is_kernel),
        .current_pc    (current_pc),
        .current_sp    (current_sp),
        .src_val       (b_val),
        .next_sp       (next_sp),
        .mem_addr      (mem_addr),
        .link_value    (link_value),
        .branch_target (branch_target)
    );

    stack_ram #(
        .WORD_SIZE         (WORD_SIZE),
        .KERNEL_STACK_TOP  (KERNEL_STACK_TOP),
        .USER_STACK_BOTTOM (USER_STACK_BOTTOM)
    ) u_stack_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// ==== sim/stack_cpu_assert.sv ====
`timescale 1ns/100ps

module stack_cpu_assert import stack_cpu_pkg::*; #(
    parameter int WORD_SIZE           = 32,
    parameter int KERNEL_STACK_TOP    = 4096,
    parameter int KERNEL_STACK_BOTTOM = 6143,
    parameter int USER_STACK_TOP      = 6144,
    parameter int USER_STACK_BOTTOM   = 8191
) (
    input logic                   clk,
    input logic                   reset,
    input logic [7:0]             paddr,
    input logic                   psel,
    input logic                   penable,
    input logic                   pwrite,
    input logic [WORD_SIZE-1:0]   pwdata,
    input logic                   pready,
    input logic                   pslverr,
    input logic                   ram_we,
    input logic                   is_kernel,
    input logic [WORD_SIZE-1:0]   current_pc,
    input logic [WORD_SIZE-1:0]   current_sp
);

    int unsigned          fail_count = 0;   // Polled by the testbench
    logic                 exec_fire;
    opcode_e              op;
    logic [WORD_SIZE-1:0] top;
    logic [WORD_SIZE-1:0] bot;

    assign exec_fire = psel & penable & pwrite & (paddr == REG_EXEC);
    assign op        = opcode_e'(pwdata[31:28]);
    assign top       = is_kernel ? WORD_SIZE'(KERNEL_STACK_TOP) : WORD_SIZE'(USER_STACK_TOP);
    assign bot       = is_kernel ? WORD_SIZE'(KERNEL_STACK_BOTTOM)
                                 : WORD_SIZE'(USER_STACK_BOTTOM);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State and bus properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    quiet_after_reset: assert property (@(posedge clk) reset |=> (!pslverr && !ram_we))
        else begin
            fail_count++;
            $error("pslverr or ram_we high right after reset");
        end

    pc_steps_by_one: assert property (@(posedge clk) disable iff (reset)
        (exec_fire && !(op inside {OP_BL, OP_BEQ})) |=> current_pc == $past(current_pc) + 1)
        else begin
            fail_count++;
            $error("PC did not advance by one on a non-branch instruction");
        end

    sp_in_bounds: assert property (@(posedge clk) disable iff (reset)
        (exec_fire && (op inside {OP_PUSH, OP_POP})) |=> (current_sp >= top && current_sp <= bot))
        else begin
            fail_count++;
            $error("SP left the stack bounds after a push or pop");
        end

    ready_in_access: assert property (@(posedge clk) (psel && penable) |-> pready)
        else begin
            fail_count++;
            $error("pready low in an access cycle");
        end

endmodule

bind step_controller stack_cpu_assert #(.WORD_SIZE(WORD_SIZE)) u_assert (
    .clk        (clk),
    .reset      (reset),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .ram_we     (ram_we),
    .is_kernel  (is_kernel),
    .current_pc (current_pc),
    .current_sp (current_sp)
);

// ==== sim/stack_cpu_tb.sv ====
`timescale 1ns/100ps

module stack_cpu_tb import stack_cpu_pkg::*; ();

    logic        clk = 1'b0;
    logic        reset;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Reference model state
    logic [31:0] m_pc;
    logic [31:0] m_sp;
    logic        m_kernel;
    logic [31:0] m_gpr [4];
    logic [31:0] m_mem [int];

    stack_cpu_top dut (.*);

    always #4 clk = ~clk;

    task automatic abort_with(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    always @(negedge clk) begin
        if (dut.u_step_controller.u_assert.fail_count != 0) begin
            abort_with("A bound assertion failed");
        end
    end

    function automatic logic [31:0] alu_word(input logic [3:0] op, input logic [1:0] rd,
                                             input logic [1:0] ra, input logic [1:0] rb,
                                             input logic [17:0] imm);
        return {op, rd, ra, rb, 4'b0, imm};
    endfunction

    function automatic logic [31:0] stack_word(input logic [3:0] op, input logic [1:0] rd,
                                               input logic [1:0] rs, input logic [21:0] tgt);
        return {op, rd, rs, 2'b0, tgt};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;                     // Setup cycle
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready) begin
            waited++;
            if (waited > 20) begin
                abort_with("Timed out waiting for pready");
            end
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);                      // Transfer completes here
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic expect_reg(input logic [7:0] addr, input string name,
                              input logic [31:0] exp);
        logic [31:0] got;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, got, err);
        if (err) begin
            abort_with($sformatf("Unexpected pslverr on read of %s", name));
        end
        if (got !== exp) begin
            abort_with($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_state();
        expect_reg(REG_PC, "pc", m_pc);
        expect_reg(REG_SP, "sp", m_sp);
        expect_reg(REG_MODE, "mode", {31'b0, m_kernel});
        for (int i = 0; i < 4; i++) begin
            expect_reg(REG_GPR0 + 8'(4 * i), $sformatf("gpr%0d", i), m_gpr[i]);
        end
    endtask

    task automatic expect_slverr(input logic wr, input logic [7:0] addr, input string what);
        logic [31:0] got;
        logic        err;
        apb_xfer(wr, addr, 32'h0, got, err);
        if (!err) begin
            abort_with($sformatf("No pslverr on %s", what));
        end
    endtask

    // Reference model of one instruction
    task automatic model_exec(input logic [31:0] w);
        logic [3:0]  op;
        logic [1:0]  rd;
        logic [1:0]  ra;
        logic [1:0]  rb;
        logic [31:0] imm;
        logic [31:0] top;
        logic [31:0] bot;
        logic [31:0] pc_nxt;
        op     = w[31:28];
        rd     = w[27:26];
        ra     = w[25:24];
        rb     = w[23:22];
        imm    = {{14{w[17]}}, w[17:0]};
        top    = m_kernel ? 32'd4096 : 32'd6144;
        bot    = m_kernel ? 32'd6143 : 32'd8191;
        pc_nxt = m_pc + 1;
        if (!(op inside {OP_PUSH, OP_POP, OP_SETSP, OP_BL}) && m_sp == 0) begin
            m_sp = bot;                      // Unset SP parks at bottom
        end
        case (op)
            OP_ADD:  m_gpr[rd] = m_gpr[ra] + m_gpr[rb];
            OP_SUB:  m_gpr[rd] = m_gpr[ra] - m_gpr[rb];
            OP_AND:  m_gpr[rd] = m_gpr[ra] & m_gpr[rb];
            OP_OR:   m_gpr[rd] = m_gpr[ra] | m_gpr[rb];
            OP_ADDI: m_gpr[rd] = m_gpr[ra] + imm;
            OP_PUSH: begin
                m_sp = (m_sp <= top) ? top : m_sp - 1;
                m_mem[m_sp] = m_gpr[ra];     // rs sits in the ra field
            end
            OP_POP: begin
                m_gpr[rd] = m_mem.exists(m_sp) ? m_mem[m_sp] : 32'h0;
                m_sp = (m_sp >= bot) ? bot : m_sp + 1;
            end
            OP_SETSP: m_sp = m_gpr[ra];
            OP_BL: begin
                m_gpr[rd] = m_pc + 1;
                pc_nxt    = {10'b0, w[21:0]};
            end
            OP_BEQ: begin
                if (m_gpr[rd] == m_gpr[ra]) begin
                    pc_nxt = {10'b0, w[21:0]};
                end
            end
            default: ;
        endcase
        m_pc = pc_nxt;
    endtask

    task automatic run_instr(input logic [31:0] w);
        logic [31:0] got;
        logic        err;
        apb_xfer(1'b1, REG_EXEC, w, got, err);
        if (err) begin
            abort_with("Unexpected pslverr on an execute write");
        end
        model_exec(w);
    endtask

    task automatic load_reg(input logic [1:0] r, input logic [17:0] value);
        run_instr(alu_word(OP_SUB, r, r, r, 18'h0));
        run_instr(alu_word(OP_ADDI, r, r, 2'd0, value));
    endtask

    task automatic push_pop(input int pushes, input int pops);
        for (int i = 0; i < pushes; i++) begin
            load_reg(2'd1, 18'($urandom));
            run_instr(stack_word(OP_PUSH, 2'd0, 2'd1, 22'h0));
            expect_reg(REG_SP, "sp", m_sp);
        end
        for (int i = 0; i < pops; i++) begin
            run_instr(stack_word(OP_POP, 2'd2, 2'd0, 22'h0));
            check_state();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] got;
        logic        err;
        void'($urandom(32'hc975));
        reset   <= 1'b1;
        paddr   <= 8'h0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= 32'h0;
        m_pc     = '0;
        m_sp     = '0;
        m_kernel = 1'b1;
        for (int i = 0; i < 4; i++) begin
            m_gpr[i] = '0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        check_state();

        // Random ALU traffic
        for (int i = 0; i < 4; i++) begin
            run_instr(alu_word(OP_ADDI, 2'(i), 2'(i), 2'd0, 18'($urandom)));
        end
        for (int n = 0; n < 12; n++) begin
            run_instr(alu_word(4'(1 + $urandom % 4), 2'($urandom), 2'($urandom),
                               2'($urandom), 18'h0));
        end
        check_state();

        // Kernel stack saturation at both ends
        load_reg(2'd3, 18'd4099);
        run_instr(stack_word(OP_SETSP, 2'd0, 2'd3, 22'h0));
        push_pop(6, 3);
        load_reg(2'd3, 18'd6144);            // One past the bottom, first push lands on it
        run_instr(stack_word(OP_SETSP, 2'd0, 2'd3, 22'h0));
        push_pop(2, 5);

        // User mode with zero SP repair
        apb_xfer(1'b1, REG_MODE, 32'h0, got, err);
        if (err) begin
            abort_with("Unexpected pslverr on mode write");
        end
        m_kernel = 1'b0;
        load_reg(2'd0, 18'd0);
        run_instr(stack_word(OP_SETSP, 2'd0, 2'd0, 22'h0));
        run_instr(32'h0);                    // NOP repairs SP
        check_state();
        push_pop(3, 3);
        load_reg(2'd3, 18'd8192);            // One past the user bottom
        run_instr(stack_word(OP_SETSP, 2'd0, 2'd3, 22'h0));
        push_pop(2, 4);
        load_reg(2'd3, 18'd6146);
        run_instr(stack_word(OP_SETSP, 2'd0, 2'd3, 22'h0));
        push_pop(4, 2);

        // Branches
        load_reg(2'd1, 18'd55);
        load_reg(2'd2, 18'd55);
        run_instr(stack_word(OP_BEQ, 2'd1, 2'd2, 22'($urandom)));
        check_state();
        load_reg(2'd2, 18'd56);
        run_instr(stack_word(OP_BEQ, 2'd1, 2'd2, 22'($urandom)));
        check_state();
        run_instr(stack_word(OP_BL, 2'd0, 2'd0, 22'($urandom)));
        check_state();

        // Invalid accesses leave state alone
        expect_slverr(1'b0, REG_EXEC, "read of the execute register");
        expect_slverr(1'b1, REG_PC, "write to the PC register");
        expect_slverr(1'b0, 8'h40, "unknown offset");
        check_state();

        @(negedge clk);
        if (dut.u_step_controller.u_assert.fail_count != 0) begin
            abort_with("A bound assertion failed");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== all.f ====
src/stack_cpu_pkg.sv
src/exec_alu.sv
src/mem_address_handler.sv
src/step_controller.sv
src/stack_ram.sv
src/stack_cpu_top.sv
sim/stack_cpu_assert.sv
sim/stack_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: stack_cpu

sources:
  - src/stack_cpu_pkg.sv
  - src/exec_alu.sv
  - src/mem_address_handler.sv
  - src/step_controller.sv
  - src/stack_ram.sv
  - src/stack_cpu_top.sv
  - target: test
    files:
      - sim/stack_cpu_assert.sv
      - sim/stack_cpu_tb.sv
